// File: Makefile
# verilator build and run of the hci subsystem testbench

TOP := tb_hci_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: include/hci_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci cluster slice constants
// widths, mux channel numbers and the apb register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef HCI_CONSTS_SVH
`define HCI_CONSTS_SVH

// data width and word address width of the tcdm bank, 64 words
`define HCI_DW       32
`define HCI_AW       6
// apb address width, enough for the window at 0x100
`define HCI_PAW      12

// static mux channels
`define HCI_NB_CHAN  3
`define HCI_CH_APB   0
`define HCI_CH_FILL  1
`define HCI_CH_SUM   2

// register offsets, all word aligned
`define HCI_REG_CMD    12'h000
`define HCI_REG_SEL    12'h004
`define HCI_REG_FILL   12'h008
`define HCI_REG_STATUS 12'h00C
`define HCI_REG_SUM    12'h010
// memory window covers 0x100 to 0x1fc, one word per 4 bytes
`define HCI_WIN_BASE   12'h100
`define HCI_WIN_MASK   12'hF00

`endif

// File: list.f
+incdir+include
source/hci_pkg.sv
source/hci_core_intf.sv
source/hci_core_mux_static.sv
source/tcdm_bank.sv
source/apb_ctrl_regs.sv
source/hci_fill_engine.sv
source/hci_sum_engine.sv
source/hci_subsystem_top.sv
testbench/tb_hci_subsystem.sv

// File: source/apb_ctrl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb control registers
// register file, memory window initiator and engine start logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

module apb_ctrl_regs (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [`HCI_PAW-1:0]             paddr_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [`HCI_DW-1:0]              pwdata_i,
  input  logic [`HCI_DW/8-1:0]            pstrb_i,
  output logic [`HCI_DW-1:0]              prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  hci_core_intf.initiator                 win_o,
  output logic [$clog2(`HCI_NB_CHAN)-1:0] sel_o,
  output hci_pkg::hci_cmd_u               cmd_o,
  output logic [`HCI_DW-1:0]              fill_o,
  output logic                            start_fill_o,
  output logic                            start_sum_o,
  input  logic                            fill_done_i,
  input  logic                            sum_done_i,
  input  logic [`HCI_DW-1:0]              sum_i,
  output logic                            done_o
);

  localparam int unsigned SW = $clog2(`HCI_NB_CHAN);
  localparam int unsigned LW = `HCI_AW + 1;

  hci_pkg::hci_cmd_u  cmd_wr;
  hci_pkg::hci_cmd_u  cmd_q;
  logic [SW-1:0]      sel_q;
  logic [`HCI_DW-1:0] fill_q;
  logic [`HCI_DW-1:0] sum_q;
  logic               busy_q;
  logic               done_q;
  logic               rd_pend_q;
  logic               access_s;
  logic               win_hit_s;
  logic               cmd_ok_s;
  logic               err_s;
  logic               wr_ok_s;
  logic               cmd_acc_s;
  logic [`HCI_DW-1:0] reg_rdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // access decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the incoming write data seen as a command, only used for CMD writes
  assign cmd_wr.raw = pwdata_i;

  assign access_s  = psel_i & penable_i;
  assign win_hit_s = ((paddr_i & `HCI_WIN_MASK) == `HCI_WIN_BASE) && (paddr_i[1:0] == 2'b00);

  // a command is taken only when idle, with a sane length and an op that fits SEL
  assign cmd_ok_s = !busy_q
                 && (cmd_wr.fields.len != '0)
                 && (cmd_wr.fields.len <= LW'(2 ** `HCI_AW))
                 && (((cmd_wr.fields.op == hci_pkg::HCI_OP_FILL) && (sel_q == SW'(`HCI_CH_FILL)))
                  || ((cmd_wr.fields.op == hci_pkg::HCI_OP_SUM) && (sel_q == SW'(`HCI_CH_SUM))));

  always_comb begin : decode_proc
    err_s     = 1'b0;
    reg_rdata = '0;
    if (win_hit_s) begin
      // the window only works while the apb channel owns the bank
      err_s = (sel_q != SW'(`HCI_CH_APB));
    end else begin
      case (paddr_i)
        `HCI_REG_CMD: begin
          reg_rdata = cmd_q.raw;
          err_s     = pwrite_i & ~cmd_ok_s;
        end
        `HCI_REG_SEL: begin
          reg_rdata = `HCI_DW'(sel_q);
          err_s     = pwrite_i & (busy_q | (pwdata_i >= `HCI_NB_CHAN));
        end
        `HCI_REG_FILL: begin
          reg_rdata = fill_q;
        end
        // status and sum are read only, a write there is refused
        `HCI_REG_STATUS: begin
          reg_rdata = `HCI_DW'({done_q, busy_q});
          err_s     = pwrite_i;
        end
        `HCI_REG_SUM: begin
          reg_rdata = sum_q;
          err_s     = pwrite_i;
        end
        default: begin
          err_s = 1'b1;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory window and apb response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // no new request while a read waits for its data
  assign win_o.req  = access_s & win_hit_s & ~err_s & ~rd_pend_q;
  assign win_o.add  = paddr_i[`HCI_AW+1:2];
  assign win_o.wen  = ~pwrite_i;
  assign win_o.data = pwdata_i;
  assign win_o.be   = pstrb_i;

  // window writes finish on gnt, window reads wait one cycle for r_valid
  assign pready_o  = access_s & (~win_hit_s | err_s | (pwrite_i ? win_o.gnt : win_o.r_valid));
  assign pslverr_o = access_s & err_s;
  assign prdata_o  = win_hit_s ? win_o.r_data : reg_rdata;

  // accepted register write, and the accepted command among them
  assign wr_ok_s   = access_s & pwrite_i & ~err_s & ~win_hit_s;
  assign cmd_acc_s = wr_ok_s & (paddr_i == `HCI_REG_CMD);

  // the engine starts at the edge that also loads CMD
  assign start_fill_o = cmd_acc_s & (cmd_wr.fields.op == hci_pkg::HCI_OP_FILL);
  assign start_sum_o  = cmd_acc_s & (cmd_wr.fields.op == hci_pkg::HCI_OP_SUM);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registers and status
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge rst_n_i) begin : regs_proc
    if (!rst_n_i) begin
      cmd_q.raw <= '0;
      sel_q     <= '0;
      fill_q    <= '0;
      sum_q     <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (wr_ok_s) begin
        case (paddr_i)
          `HCI_REG_CMD:  cmd_q.raw <= pwdata_i;
          `HCI_REG_SEL:  sel_q     <= pwdata_i[SW-1:0];
          `HCI_REG_FILL: fill_q    <= pwdata_i;
          default: ;
        endcase
      end
      // sum_i already includes the last word in the done cycle
      if (sum_done_i) begin
        sum_q <= sum_i;
      end
      // done stays up until the next command is accepted
      if (cmd_acc_s) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (fill_done_i || sum_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      rd_pend_q <= (rd_pend_q & ~win_o.r_valid) | (win_o.req & win_o.gnt & win_o.wen);
    end
  end

  assign sel_o  = sel_q;
  assign cmd_o  = cmd_q;
  assign fill_o = fill_q;
  assign done_o = done_q;

endmodule

// File: source/hci_core_intf.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci core port
// simplified tcdm request and response channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

interface hci_core_intf;

  // request side, held stable by the initiator until gnt
  logic                 req;
  logic [`HCI_AW-1:0]   add;
  // wen high means a read
  logic                 wen;
  logic [`HCI_DW-1:0]   data;
  logic [`HCI_DW/8-1:0] be;

  // response side, r_valid follows a granted read by one cycle
  logic                 gnt;
  logic                 r_valid;
  logic [`HCI_DW-1:0]   r_data;

  modport initiator (
    output req, add, wen, data, be,
    input  gnt, r_valid, r_data
  );

  modport target (
    input  req, add, wen, data, be,
    output gnt, r_valid, r_data
  );

endinterface

// File: source/hci_core_mux_static.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci static multiplexer
// routes the one selected channel to the bank, no arbitration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

module hci_core_mux_static #(
  parameter int unsigned NB_CHAN = 3
) (
  // clock and reset stay on the port list like the rest of the hci family
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [$clog2(NB_CHAN)-1:0] sel_i,
  hci_core_intf.target               in_i [0:NB_CHAN-1],
  hci_core_intf.initiator            out_o
);

  localparam int unsigned SW = $clog2(NB_CHAN);

  // request fields of every channel gathered into arrays for indexing
  logic [NB_CHAN-1:0]                    in_req;
  logic [NB_CHAN-1:0]                    in_wen;
  logic [NB_CHAN-1:0][`HCI_AW-1:0]       in_add;
  logic [NB_CHAN-1:0][`HCI_DW-1:0]       in_data;
  logic [NB_CHAN-1:0][`HCI_DW/8-1:0]     in_be;

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    assign in_req[ii]  = in_i[ii].req;
    assign in_wen[ii]  = in_i[ii].wen;
    assign in_add[ii]  = in_i[ii].add;
    assign in_data[ii] = in_i[ii].data;
    assign in_be[ii]   = in_i[ii].be;

    // a channel that is not selected never sees gnt, so it just stalls
    assign in_i[ii].gnt     = (sel_i == SW'(ii)) ? out_o.gnt : 1'b0;
    assign in_i[ii].r_valid = (sel_i == SW'(ii)) ? out_o.r_valid : 1'b0;
    // read data goes to everyone, r_valid says who owns it
    assign in_i[ii].r_data  = out_o.r_data;
  end

  // software only changes sel_i while idle, so the switch is glitch free
  assign out_o.req  = in_req[sel_i];
  assign out_o.add  = in_add[sel_i];
  assign out_o.wen  = in_wen[sel_i];
  assign out_o.data = in_data[sel_i];
  assign out_o.be   = in_be[sel_i];

endmodule

// File: source/hci_fill_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci fill engine
// writes fill+i to word base+i for len words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

module hci_fill_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  hci_pkg::hci_cmd_u  cmd_i,
  input  logic [`HCI_DW-1:0] fill_i,
  hci_core_intf.initiator    port_o,
  output logic               done_o
);

  localparam int unsigned LW = `HCI_AW + 1;

  logic               active_q;
  logic [LW-1:0]      cnt_q;
  logic [`HCI_DW-1:0] fill_q;
  logic               last_s;

  // cmd_i is frozen while busy, so it is read directly
  assign last_s = (cnt_q == cmd_i.fields.len - LW'(1));

  // one write per cycle, the address wraps at the end of the bank
  assign port_o.req  = active_q;
  assign port_o.add  = cmd_i.fields.base + cnt_q[`HCI_AW-1:0];
  assign port_o.wen  = 1'b0;
  assign port_o.data = fill_q + `HCI_DW'(cnt_q);
  assign port_o.be   = '1;

  // done in the cycle of the last grant
  assign done_o = active_q & port_o.gnt & last_s;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_proc
    if (!rst_n_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q && port_o.gnt) begin
      cnt_q <= cnt_q + LW'(1);
      if (last_s) begin
        active_q <= 1'b0;
      end
    end
  end

  // the fill value is captured once so a later FILL write cannot disturb a run
  always_ff @(posedge clk_i) begin : fill_proc
    if (start_i) begin
      fill_q <= fill_i;
    end
  end

endmodule

// File: source/hci_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci cluster slice types
// operation encoding and the command word seen two ways
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "hci_consts.svh"

package hci_pkg;

  // engine operation carried in the low bits of the command word
  typedef enum logic [1:0] {
    HCI_OP_NONE = 2'd0,
    HCI_OP_FILL = 2'd1,
    HCI_OP_SUM  = 2'd2
  } hci_op_e;

  // len counts words from 1 to 64, so it needs one bit more than an address
  typedef struct packed {
    logic [`HCI_DW-`HCI_AW-10:0] rsvd;
    logic [`HCI_AW-1:0]          base;
    logic [`HCI_AW:0]            len;
    hci_op_e                     op;
  } hci_cmd_t;

  // apb writes the word as raw, the engines and start decode use the fields
  typedef union packed {
    logic [`HCI_DW-1:0] raw;
    hci_cmd_t           fields;
  } hci_cmd_u;

endpackage

// File: source/hci_subsystem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci subsystem top
// apb host, fill and sum engines sharing one tcdm bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

module hci_subsystem_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [`HCI_PAW-1:0]  paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [`HCI_DW-1:0]   pwdata_i,
  input  logic [`HCI_DW/8-1:0] pstrb_i,
  output logic [`HCI_DW-1:0]   prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  output logic                 done_o
);

  logic [$clog2(`HCI_NB_CHAN)-1:0] sel_s;
  hci_pkg::hci_cmd_u               cmd_s;
  logic [`HCI_DW-1:0]              fill_s;
  logic [`HCI_DW-1:0]              sum_s;
  logic                            start_fill_s;
  logic                            start_sum_s;
  logic                            fill_done_s;
  logic                            sum_done_s;

  // one port per mux channel plus the bank side
  hci_core_intf chan_if [0:`HCI_NB_CHAN-1] ();
  hci_core_intf bank_if ();

  apb_ctrl_regs regs_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .pstrb_i      (pstrb_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .win_o        (chan_if[`HCI_CH_APB]),
    .sel_o        (sel_s),
    .cmd_o        (cmd_s),
    .fill_o       (fill_s),
    .start_fill_o (start_fill_s),
    .start_sum_o  (start_sum_s),
    .fill_done_i  (fill_done_s),
    .sum_done_i   (sum_done_s),
    .sum_i        (sum_s),
    .done_o       (done_o)
  );

  hci_fill_engine fill_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_fill_s),
    .cmd_i   (cmd_s),
    .fill_i  (fill_s),
    .port_o  (chan_if[`HCI_CH_FILL]),
    .done_o  (fill_done_s)
  );

  hci_sum_engine sum_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start_sum_s),
    .cmd_i   (cmd_s),
    .port_o  (chan_if[`HCI_CH_SUM]),
    .sum_o   (sum_s),
    .done_o  (sum_done_s)
  );

  // SEL picks the owner of the bank, changed only while idle
  hci_core_mux_static #(
    .NB_CHAN (`HCI_NB_CHAN)
  ) mux_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .sel_i   (sel_s),
    .in_i    (chan_if),
    .out_o   (bank_if)
  );

  tcdm_bank bank_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .port_i  (bank_if)
  );

endmodule

// File: source/hci_sum_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci sum engine
// reads len words from base and adds them modulo 2^32
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

module hci_sum_engine (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               start_i,
  input  hci_pkg::hci_cmd_u  cmd_i,
  hci_core_intf.initiator    port_o,
  output logic [`HCI_DW-1:0] sum_o,
  output logic               done_o
);

  localparam int unsigned LW = `HCI_AW + 1;

  logic               active_q;
  // issue and response counters run apart, reads overlap by one
  logic [LW-1:0]      iss_q;
  logic [LW-1:0]      rsp_q;
  logic [`HCI_DW-1:0] acc_q;

  // keep issuing until len reads have been granted
  assign port_o.req  = active_q & (iss_q < cmd_i.fields.len);
  assign port_o.add  = cmd_i.fields.base + iss_q[`HCI_AW-1:0];
  assign port_o.wen  = 1'b1;
  assign port_o.data = '0;
  assign port_o.be   = '1;

  // sum_o already holds the word that arrives this cycle
  assign sum_o  = port_o.r_valid ? acc_q + port_o.r_data : acc_q;
  assign done_o = active_q & port_o.r_valid & (rsp_q == cmd_i.fields.len - LW'(1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_proc
    if (!rst_n_i) begin
      active_q <= 1'b0;
      iss_q    <= '0;
      rsp_q    <= '0;
      acc_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      iss_q    <= '0;
      rsp_q    <= '0;
      acc_q    <= '0;
    end else if (active_q) begin
      if (port_o.req && port_o.gnt) begin
        iss_q <= iss_q + LW'(1);
      end
      if (port_o.r_valid) begin
        rsp_q <= rsp_q + LW'(1);
        acc_q <= sum_o;
      end
      // the last response ends the run
      if (done_o) begin
        active_q <= 1'b0;
      end
    end
  end

endmodule

// File: source/tcdm_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tcdm bank
// single ported word memory, byte writes, one cycle read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

module tcdm_bank (
  input  logic         clk_i,
  input  logic         rst_n_i,
  hci_core_intf.target port_i
);

  localparam int unsigned NB_WORDS = 2 ** `HCI_AW;

  logic [`HCI_DW-1:0] mem_q [0:NB_WORDS-1];
  logic [`HCI_DW-1:0] rdata_q;
  logic               rvalid_q;

  // the bank is never busy, every request is taken in its own cycle
  assign port_i.gnt = port_i.req;

  // storage and read data path
  always_ff @(posedge clk_i) begin : mem_proc
    if (port_i.req && !port_i.wen) begin
      for (int b = 0; b < `HCI_DW / 8; b++) begin
        if (port_i.be[b]) begin
          mem_q[port_i.add][8*b +: 8] <= port_i.data[8*b +: 8];
        end
      end
    end
    if (port_i.req && port_i.wen) begin
      rdata_q <= mem_q[port_i.add];
    end
  end

  // response strobe for reads only, writes are silent
  always_ff @(posedge clk_i or negedge rst_n_i) begin : rvalid_proc
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= port_i.req & port_i.wen;
    end
  end

  assign port_i.r_valid = rvalid_q;
  assign port_i.r_data  = rdata_q;

endmodule

// File: testbench/tb_hci_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hci subsystem testbench
// random apb traffic checked against a memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "hci_consts.svh"

module tb_hci_subsystem;

  localparam int unsigned NB_WORDS = 2 ** `HCI_AW;
  // a full readback is 64 reads of 4 cycles, the whole run is a few thousand cycles
  localparam int unsigned CYCLE_LIMIT = 20000;

  logic                 clk;
  logic                 rst_n;
  logic [`HCI_PAW-1:0]  paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [`HCI_DW-1:0]   pwdata;
  logic [`HCI_DW/8-1:0] pstrb;
  logic [`HCI_DW-1:0]   prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 done;

  logic [31:0]          rng_state;
  logic [31:0]          model_mem [0:NB_WORDS-1];
  logic [31:0]          exp_fill;
  logic [31:0]          exp_sum;
  int unsigned          cycles;

  hci_subsystem_top dut_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .done_o    (done)
  );

  initial begin : clk_proc
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog over the whole run
  initial begin : watchdog_proc
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        abort_run("the run went past its cycle limit without finishing");
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // xorshift32, the state lives in rng_state
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // command word from bit 0 upward: op, len, base, then reserved zeros
  function automatic logic [31:0] make_cmd(input logic [1:0] op, input logic [6:0] len,
                                           input logic [5:0] base);
    return {17'd0, base, len, op};
  endfunction

  function automatic logic [`HCI_PAW-1:0] win_addr(input logic [5:0] a);
    return `HCI_WIN_BASE + {4'b0, a, 2'b00};
  endfunction

  function automatic logic [31:0] model_sum(input logic [5:0] base, input logic [6:0] len);
    logic [31:0] s;
    s = '0;
    for (int i = 0; i < len; i++) begin
      s = s + model_mem[6'(base + i)];
    end
    return s;
  endfunction

  // setup phase, then access phase held until pready; waits counts the wait states
  task automatic apb_transfer(input logic [`HCI_PAW-1:0] addr, input logic wr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err,
                              output int waits);
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    pstrb   = strb;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waits   = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_write(input logic [`HCI_PAW-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(addr, 1'b1, data, 4'hF, rdata, err, waits);
    check_value("pslverr_o on register write", err, 0);
    check_value("register write wait states", waits, 0);
  endtask

  task automatic reg_read_check(input string name, input logic [`HCI_PAW-1:0] addr,
                                input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(addr, 1'b0, '0, 4'h0, rdata, err, waits);
    check_value("pslverr_o on register read", err, 0);
    check_value("register read wait states", waits, 0);
    check_value(name, rdata, exp);
  endtask

  // the access must fail with pslverr and complete at once
  task automatic expect_reject(input string name, input logic [`HCI_PAW-1:0] addr,
                               input logic wr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(addr, wr, data, 4'hF, rdata, err, waits);
    check_value(name, err, 1);
    check_value("rejected access wait states", waits, 0);
  endtask

  task automatic win_write(input logic [5:0] a, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(win_addr(a), 1'b1, data, strb, rdata, err, waits);
    check_value("pslverr_o on window write", err, 0);
    check_value("window write wait states", waits, 0);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_mem[a][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic win_read_check(input logic [5:0] a);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(win_addr(a), 1'b0, '0, 4'h0, rdata, err, waits);
    check_value("pslverr_o on window read", err, 0);
    check_value("window read wait states", waits, 1);
    check_value($sformatf("prdata_o of word %0d", a), rdata, model_mem[a]);
  endtask

  task automatic check_memory();
    reg_write(`HCI_REG_SEL, `HCI_CH_APB);
    for (int a = 0; a < NB_WORDS; a++) begin
      win_read_check(6'(a));
    end
  endtask

  task automatic window_traffic(input int unsigned n);
    reg_write(`HCI_REG_SEL, `HCI_CH_APB);
    for (int k = 0; k < n; k++) begin
      win_write(6'(next_rand()), next_rand(), 4'(next_rand()));
      win_read_check(6'(next_rand()));
    end
  endtask

  // counts falling edges from the start of the run until done_o is seen
  task automatic wait_done(output int n);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!done);
  endtask

  // with busy_probe set the run also tries the accesses that busy must refuse
  task automatic run_fill(input logic [5:0] base, input logic [6:0] len,
                          input logic [31:0] value, input logic busy_probe);
    int n;
    reg_write(`HCI_REG_SEL, `HCI_CH_FILL);
    reg_write(`HCI_REG_FILL, value);
    exp_fill = value;
    reg_write(`HCI_REG_CMD, make_cmd(hci_pkg::HCI_OP_FILL, len, base));
    if (busy_probe) begin
      // done from the last run is cleared, busy is up
      reg_read_check("STATUS while busy", `HCI_REG_STATUS, 32'h1);
      expect_reject("pslverr_o on SEL write while busy", `HCI_REG_SEL, 1'b1, 0);
      expect_reject("pslverr_o on CMD write while busy", `HCI_REG_CMD, 1'b1,
                    make_cmd(hci_pkg::HCI_OP_FILL, 7'd1, 6'd0));
      reg_read_check("SEL after busy writes", `HCI_REG_SEL, `HCI_CH_FILL);
      wait_done(n);
    end else begin
      wait_done(n);
      check_value("fill done latency", n, 32'(len) + 1);
    end
    for (int i = 0; i < len; i++) begin
      model_mem[6'(base + i)] = value + 32'(i);
    end
    check_value("done_o after fill", done, 1);
    reg_read_check("STATUS after fill", `HCI_REG_STATUS, 32'h2);
  endtask

  task automatic run_sum(input logic [5:0] base, input logic [6:0] len);
    int n;
    reg_write(`HCI_REG_SEL, `HCI_CH_SUM);
    reg_write(`HCI_REG_CMD, make_cmd(hci_pkg::HCI_OP_SUM, len, base));
    wait_done(n);
    check_value("sum done latency", n, 32'(len) + 2);
    exp_sum = model_sum(base, len);
    check_value("done_o after sum", done, 1);
    reg_read_check("SUM", `HCI_REG_SUM, exp_sum);
    reg_read_check("STATUS after sum", `HCI_REG_STATUS, 32'h2);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : main_proc
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    pstrb     = '0;
    rng_state = 32'h4645_63de;
    exp_fill  = '0;
    exp_sum   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset values
    check_value("done_o after reset", done, 0);
    check_value("pslverr_o after reset", pslverr, 0);
    reg_read_check("SEL after reset", `HCI_REG_SEL, 0);
    reg_read_check("STATUS after reset", `HCI_REG_STATUS, 0);
    reg_read_check("SUM after reset", `HCI_REG_SUM, 0);

    // the bank powers up unknown, so every word gets a known value first
    for (int a = 0; a < NB_WORDS; a++) begin
      win_write(6'(a), next_rand(), 4'hF);
    end
    window_traffic(48);
    check_memory();

    run_fill(6'(next_rand()), 7'(next_rand() % 64 + 1), next_rand(), 1'b0);
    check_memory();
    run_sum(6'(next_rand()), 7'(next_rand() % 64 + 1));

    // refused accesses while the fill channel owns the bank
    reg_write(`HCI_REG_SEL, `HCI_CH_FILL);
    expect_reject("pslverr_o on window write off channel", win_addr(6'(next_rand())),
                  1'b1, next_rand());
    expect_reject("pslverr_o on window read off channel", win_addr(6'(next_rand())),
                  1'b0, 0);
    expect_reject("pslverr_o on CMD op mismatch", `HCI_REG_CMD, 1'b1,
                  make_cmd(hci_pkg::HCI_OP_SUM, 7'd4, 6'd0));
    expect_reject("pslverr_o on CMD with no op", `HCI_REG_CMD, 1'b1,
                  make_cmd(hci_pkg::HCI_OP_NONE, 7'd4, 6'd0));
    expect_reject("pslverr_o on unmapped write", 12'h014, 1'b1, next_rand());
    expect_reject("pslverr_o on unmapped read", 12'h0FC, 1'b0, 0);
    expect_reject("pslverr_o beyond the window", 12'h200, 1'b1, next_rand());
    expect_reject("pslverr_o on misaligned window", 12'h102, 1'b0, 0);
    check_value("done_o after rejects", done, 1);
    reg_read_check("SEL after rejects", `HCI_REG_SEL, `HCI_CH_FILL);
    reg_read_check("FILL after rejects", `HCI_REG_FILL, exp_fill);
    reg_read_check("SUM after rejects", `HCI_REG_SUM, exp_sum);
    reg_read_check("STATUS after rejects", `HCI_REG_STATUS, 32'h2);
    // a refused window write must never have reached the bank
    check_memory();

    // a long fill leaves time to poke at the busy rules
    run_fill(6'(next_rand()), 7'd64, next_rand(), 1'b1);
    check_memory();

    // rotate the owner of the bank round by round
    for (int r = 0; r < 6; r++) begin
      for (int s = 0; s < 3; s++) begin
        case ((r + s) % 3)
          0: window_traffic(10);
          1: run_fill(6'(next_rand()), 7'(next_rand() % 64 + 1), next_rand(), 1'b0);
          default: run_sum(6'(next_rand()), 7'(next_rand() % 64 + 1));
        endcase
      end
    end
    check_memory();

    $display("Test passed");
    $finish;
  end

endmodule
